// File: ray_march_top.f
hw/ray_pkg.sv
hw/pixel_scan.sv
hw/ray_stage.sv
hw/ray_shader.sv
hw/frame_buffer.sv
hw/ray_march_top.sv
sim/ray_march_assertions.sv
sim/tb_ray_march.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ray_march -Mdir obj_dir -f ray_march_top.f

out=$(./obj_dir/Vtb_ray_march 2>&1 || true)
echo "$out"

# the run passes only if the testbench reported success
echo "$out" | grep -qx "Simulation PASSED"

// File: sim/tb_ray_march.sv
`default_nettype none

module tb_ray_march;

    localparam int SCREEN_WIDTH = 32;
    localparam int SCREEN_HEIGHT = 24;
    localparam ray_pkg::fix_t EPSILON = 16'h0010;
    localparam ray_pkg::fix_t MAX_DIST = 16'h3200;
    localparam int DONE_TIMEOUT = 500000;

    logic clk;
    logic reset;
    logic i_start;
    ray_pkg::fix_t i_eye_height;
    logic [7:0] i_tilt_step;
    ray_pkg::shade_cfg_t i_shade;
    ray_pkg::coord_t i_read_x;
    ray_pkg::coord_t i_read_y;
    ray_pkg::color_t o_color;
    logic o_done;
    logic frame_open;

    ray_march_top #(
        .SCREEN_WIDTH  (SCREEN_WIDTH),
        .SCREEN_HEIGHT (SCREEN_HEIGHT),
        .RAY_STAGES    (3),
        .EPSILON       (EPSILON),
        .MAX_DIST      (MAX_DIST)
    ) u_dut (
        .clk          (clk),
        .reset        (reset),
        .i_start      (i_start),
        .i_eye_height (i_eye_height),
        .i_tilt_step  (i_tilt_step),
        .i_shade      (i_shade),
        .i_read_x     (i_read_x),
        .i_read_y     (i_read_y),
        .o_color      (o_color),
        .o_done       (o_done)
    );

    always #2 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("[ERROR] time %0t: %s expected 0x%0h, got 0x%0h",
                               $time, name, expected, actual));
        end
    endtask

    // only a requested frame may end with o_done
    always @(posedge clk) begin
        if (!reset && !frame_open) begin
            check_value("o_done", 32'd0, 32'(o_done));
        end
    end

    // byte of the integer part after scaling depth by 2^shift
    function automatic logic [7:0] depth_byte(input logic [15:0] depth, input logic [3:0] shift);
        logic [31:0] scaled;
        scaled = ({16'd0, depth} << shift) >> 8;
        return scaled[7:0];
    endfunction

    function automatic logic [7:0] fogged_channel(input logic [7:0] raw, input logic enable,
                                                  input logic show, input logic fog_enable,
                                                  input logic [7:0] fog);
        logic [7:0] value;
        value = (enable && show) ? raw : 8'd0;
        if (fog_enable) begin
            value = (fog < value) ? value - fog : 8'd0;
        end
        return value;
    endfunction

    // march one pixel over the ground plane until a flag is set, then shade it
    function automatic ray_pkg::color_t expected_pixel(input int x, input int y,
                                                       input logic [15:0] eye,
                                                       input logic [7:0] tilt,
                                                       input ray_pkg::shade_cfg_t cfg);
        logic [15:0] height;
        logic [15:0] depth;
        logic [15:0] descent;
        logic [15:0] next_depth;
        logic [31:0] sum;
        logic [31:0] drop;
        logic hit;
        logic max_depth;
        logic [7:0] fog;
        ray_pkg::color_t color;
        descent = (y > SCREEN_HEIGHT / 2) ? 16'((y - SCREEN_HEIGHT / 2) * tilt) : 16'd0;
        height = eye;
        depth = 16'd0;
        hit = 1'b0;
        max_depth = 1'b0;
        while (!hit && !max_depth) begin
            hit = height < EPSILON;
            sum = {16'd0, depth} + {16'd0, height};
            next_depth = (sum > 32'h0000_ffff) ? 16'hffff : sum[15:0];
            max_depth = next_depth >= MAX_DIST;
            if (!hit && !max_depth) begin
                drop = ({16'd0, height} * {16'd0, descent}) >> 8;
                height = (drop >= {16'd0, height}) ? 16'd0 : height - drop[15:0];
                depth = next_depth;
            end
        end
        fog = depth_byte(depth, cfg.fog_shift);
        color.red = fogged_channel(depth_byte(depth, cfg.red_shift), cfg.red_enable,
                                   hit && !max_depth, cfg.fog_enable, fog) >> 5;
        color.green = fogged_channel(depth_byte(depth, cfg.green_shift), cfg.green_enable,
                                     hit && !max_depth, cfg.fog_enable, fog) >> 4;
        color.blue = fogged_channel(depth_byte(depth, cfg.blue_shift), cfg.blue_enable,
                                    hit && !max_depth, cfg.fog_enable, fog) >> 5;
        return color;
    endfunction

    task automatic wait_done();
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!o_done) begin
            cycles++;
            if (cycles > DONE_TIMEOUT) begin
                fail_run("timeout: o_done never arrived after i_start");
            end
            @(posedge clk);
        end
        frame_open <= 1'b0;
    endtask

    // read every pixel back one cycle after its address
    task automatic read_frame(input logic [15:0] eye, input logic [7:0] tilt,
                              input ray_pkg::shade_cfg_t cfg, input logic upper_black);
        for (int y = 0; y < SCREEN_HEIGHT; y++) begin
            for (int x = 0; x < SCREEN_WIDTH; x++) begin
                @(posedge clk);
                i_read_x <= ray_pkg::coord_t'(x);
                i_read_y <= ray_pkg::coord_t'(y);
                @(posedge clk);
                @(posedge clk);
                if (upper_black && y <= SCREEN_HEIGHT / 2) begin
                    check_value("o_color", 32'd0, 32'(o_color));
                end
                if (!cfg.red_enable) begin
                    check_value("o_color.red", 32'd0, 32'(o_color.red));
                end
                if (!cfg.green_enable) begin
                    check_value("o_color.green", 32'd0, 32'(o_color.green));
                end
                if (!cfg.blue_enable) begin
                    check_value("o_color.blue", 32'd0, 32'(o_color.blue));
                end
                check_value("o_color", 32'(expected_pixel(x, y, eye, tilt, cfg)), 32'(o_color));
            end
        end
    endtask

    task automatic run_frame(input logic [15:0] eye, input logic [7:0] tilt,
                             input ray_pkg::shade_cfg_t cfg, input logic upper_black,
                             input logic busy_start);
        @(posedge clk);
        i_eye_height <= eye;
        i_tilt_step <= tilt;
        i_shade <= cfg;
        i_start <= 1'b1;
        frame_open <= 1'b1;
        @(posedge clk);
        i_start <= 1'b0;
        // a second strobe mid-frame must be ignored
        if (busy_start) begin
            repeat (4) @(posedge clk);
            i_start <= 1'b1;
            @(posedge clk);
            i_start <= 1'b0;
        end
        wait_done();
        read_frame(eye, tilt, cfg, upper_black);
    endtask

    logic [15:0] eye;
    logic [7:0] tilt;
    ray_pkg::shade_cfg_t cfg;

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        i_start = 1'b0;
        i_eye_height = '0;
        i_tilt_step = '0;
        i_shade = '0;
        i_read_x = '0;
        i_read_y = '0;
        frame_open = 1'b0;
        void'($urandom(43));
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // idle with no frame requested
        repeat (20) begin
            @(posedge clk);
            check_value("o_done", 32'd0, 32'(o_done));
        end

        // fully random frame
        eye = 16'h0100 + 16'($urandom % 32'h0700);
        tilt = 8'($urandom);
        cfg = ray_pkg::shade_cfg_t'(20'($urandom));
        run_frame(eye, tilt, cfg, 1'b0, 1'b0);

        // sky rows stay black without fog
        eye = 16'h0100 + 16'($urandom % 32'h0700);
        tilt = 8'($urandom);
        cfg = ray_pkg::shade_cfg_t'(20'($urandom));
        cfg.fog_enable = 1'b0;
        run_frame(eye, tilt, cfg, 1'b1, 1'b0);

        // fog with at least one channel switched off
        eye = 16'h0100 + 16'($urandom % 32'h0700);
        tilt = 8'($urandom);
        cfg = ray_pkg::shade_cfg_t'(20'($urandom));
        cfg.fog_enable = 1'b1;
        cfg.fog_shift = 4'($urandom % 6);
        if (cfg.red_enable && cfg.green_enable && cfg.blue_enable) begin
            cfg.green_enable = 1'b0;
        end
        run_frame(eye, tilt, cfg, 1'b0, 1'b0);

        // back-to-back frames with a stray strobe while busy
        repeat (5) begin
            eye = 16'h0100 + 16'($urandom % 32'h0700);
            tilt = 8'($urandom);
            cfg = ray_pkg::shade_cfg_t'(20'($urandom));
            run_frame(eye, tilt, cfg, 1'b0, 1'b1);
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/ray_march_assertions.sv
`default_nettype none

module ray_march_assertions (
    input wire clk,
    input wire reset,
    input wire i_start,
    input wire o_done
);

    logic seen_start;

    // remembers whether a frame was ever requested
    always_ff @(posedge clk) begin
        if (reset) begin
            seen_start <= 1'b0;
        end else if (i_start) begin
            seen_start <= 1'b1;
        end
    end

    done_low_in_reset: assert property (@(posedge clk) reset |=> !o_done)
        else $error("o_done high while in reset");

    done_single_pulse: assert property (@(posedge clk) disable iff (reset)
        o_done |=> !o_done)
        else $error("o_done held high for two cycles");

    done_after_start: assert property (@(posedge clk) disable iff (reset)
        o_done |-> seen_start)
        else $error("o_done without any earlier i_start");

endmodule

bind ray_march_top ray_march_assertions u_assertions (
    .clk     (clk),
    .reset   (reset),
    .i_start (i_start),
    .o_done  (o_done)
);

`default_nettype wire

// File: hw/ray_march_top.sv
`default_nettype none

module ray_march_top #(
    parameter int            SCREEN_WIDTH  = 32,
    parameter int            SCREEN_HEIGHT = 24,
    parameter int            RAY_STAGES    = 3,
    parameter ray_pkg::fix_t EPSILON       = 16'h0010,
    parameter ray_pkg::fix_t MAX_DIST      = 16'h3200
) (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      i_start,
    input  wire ray_pkg::fix_t       i_eye_height,
    input  wire [7:0]                i_tilt_step,
    input  wire ray_pkg::shade_cfg_t i_shade,
    input  wire ray_pkg::coord_t     i_read_x,
    input  wire ray_pkg::coord_t     i_read_y,
    output ray_pkg::color_t          o_color,
    output logic                     o_done
);

    // slot 0 is the head register, the last slot returns to the scan
    ray_pkg::ray_t ray_chain [RAY_STAGES+1];

    logic write;
    ray_pkg::coord_t write_x;
    ray_pkg::coord_t write_y;
    ray_pkg::color_t write_color;

    pixel_scan #(
        .SCREEN_WIDTH  (SCREEN_WIDTH),
        .SCREEN_HEIGHT (SCREEN_HEIGHT)
    ) u_pixel_scan (
        .clk          (clk),
        .reset        (reset),
        .i_start      (i_start),
        .i_eye_height (i_eye_height),
        .i_tilt_step  (i_tilt_step),
        .i_ray_back   (ray_chain[RAY_STAGES]),
        .o_ray_head   (ray_chain[0]),
        .o_done       (o_done)
    );

    for (genvar i = 0; i < RAY_STAGES; i++) begin : g_stage
        ray_stage #(
            .EPSILON  (EPSILON),
            .MAX_DIST (MAX_DIST)
        ) u_ray_stage (
            .clk   (clk),
            .reset (reset),
            .i_ray (ray_chain[i]),
            .o_ray (ray_chain[i+1])
        );
    end

    ray_shader u_ray_shader (
        .i_ray     (ray_chain[RAY_STAGES]),
        .i_shade   (i_shade),
        .o_write   (write),
        .o_write_x (write_x),
        .o_write_y (write_y),
        .o_color   (write_color)
    );

    frame_buffer #(
        .SCREEN_WIDTH  (SCREEN_WIDTH),
        .SCREEN_HEIGHT (SCREEN_HEIGHT)
    ) u_frame_buffer (
        .clk           (clk),
        .i_write       (write),
        .i_write_x     (write_x),
        .i_write_y     (write_y),
        .i_write_color (write_color),
        .i_read_x      (i_read_x),
        .i_read_y      (i_read_y),
        .o_color       (o_color)
    );

endmodule

`default_nettype wire

// File: hw/frame_buffer.sv
`default_nettype none

module frame_buffer #(
    parameter int SCREEN_WIDTH  = 32,
    parameter int SCREEN_HEIGHT = 24
) (
    input  wire                  clk,
    input  wire                  i_write,
    input  wire ray_pkg::coord_t i_write_x,
    input  wire ray_pkg::coord_t i_write_y,
    input  wire ray_pkg::color_t i_write_color,
    input  wire ray_pkg::coord_t i_read_x,
    input  wire ray_pkg::coord_t i_read_y,
    output ray_pkg::color_t      o_color
);

    localparam int DEPTH = SCREEN_WIDTH * SCREEN_HEIGHT;
    localparam int ADDR_W = $clog2(DEPTH);

    ray_pkg::color_t mem [DEPTH];
    logic [ADDR_W-1:0] write_addr;
    logic [ADDR_W-1:0] read_addr;

    // raster order, x + y * width
    assign write_addr = ADDR_W'(i_write_x) + ADDR_W'(i_write_y) * ADDR_W'(SCREEN_WIDTH);
    assign read_addr = ADDR_W'(i_read_x) + ADDR_W'(i_read_y) * ADDR_W'(SCREEN_WIDTH);

    always_ff @(posedge clk) begin
        if (i_write) begin
            mem[write_addr] <= i_write_color;
        end
        o_color <= mem[read_addr];
    end

endmodule

`default_nettype wire

// File: hw/ray_shader.sv
`default_nettype none

module ray_shader (
    input  wire ray_pkg::ray_t      i_ray,
    input  wire ray_pkg::shade_cfg_t i_shade,
    output logic                    o_write,
    output ray_pkg::coord_t         o_write_x,
    output ray_pkg::coord_t         o_write_y,
    output ray_pkg::color_t         o_color
);

    logic show;
    logic [7:0] fog;
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;

    // low byte of the integer part of depth scaled by 2^shift
    function automatic logic [7:0] scaled_depth(input ray_pkg::fix_t depth,
                                                input logic [3:0] shift);
        logic [31:0] scaled;
        scaled = {16'b0, depth} << shift;
        return scaled[ray_pkg::FRAC_BITS+7:ray_pkg::FRAC_BITS];
    endfunction

    function automatic logic [7:0] shade_channel(input logic [7:0] raw,
                                                 input logic enable,
                                                 input logic visible,
                                                 input logic fog_enable,
                                                 input logic [7:0] fog_value);
        logic [7:0] value;
        value = (enable && visible) ? raw : 8'd0;
        // fog darkens with distance, never below black
        if (fog_enable) begin
            value = (fog_value < value) ? value - fog_value : 8'd0;
        end
        return value;
    endfunction

    assign o_write = i_ray.valid && (i_ray.hit || i_ray.max_depth);
    assign o_write_x = i_ray.pixel_x;
    assign o_write_y = i_ray.pixel_y;

    // rays that ran out of distance stay black
    assign show = i_ray.hit && !i_ray.max_depth;
    assign fog = scaled_depth(i_ray.depth, i_shade.fog_shift);

    assign red = shade_channel(scaled_depth(i_ray.depth, i_shade.red_shift),
                               i_shade.red_enable, show, i_shade.fog_enable, fog);
    assign green = shade_channel(scaled_depth(i_ray.depth, i_shade.green_shift),
                                 i_shade.green_enable, show, i_shade.fog_enable, fog);
    assign blue = shade_channel(scaled_depth(i_ray.depth, i_shade.blue_shift),
                                i_shade.blue_enable, show, i_shade.fog_enable, fog);

    assign o_color.red = red[7:5];
    assign o_color.green = green[7:4];
    assign o_color.blue = blue[7:5];

endmodule

`default_nettype wire

// File: hw/ray_stage.sv
`default_nettype none

module ray_stage #(
    parameter ray_pkg::fix_t EPSILON  = 16'h0010,
    parameter ray_pkg::fix_t MAX_DIST = 16'h3200
) (
    input  wire                clk,
    input  wire                reset,
    input  wire ray_pkg::ray_t i_ray,
    output ray_pkg::ray_t      o_ray
);

    localparam int FIX_W = $bits(ray_pkg::fix_t);
    localparam int PROD_W = 2 * FIX_W;
    localparam int STEP_W = PROD_W - ray_pkg::FRAC_BITS;

    logic active_in;

    // first cycle registers
    ray_pkg::ray_t stage_ray;
    logic stage_hit;
    logic [PROD_W-1:0] stage_prod;

    // second cycle decisions
    logic stage_active;
    logic [FIX_W:0] depth_sum;
    ray_pkg::fix_t new_depth;
    logic new_max;
    logic [STEP_W-1:0] step_full;
    ray_pkg::fix_t new_height;

    assign active_in = i_ray.valid && !i_ray.hit && !i_ray.max_depth;

    // distance to the plane is the ray height
    always_ff @(posedge clk) begin
        if (reset) begin
            stage_ray.valid <= 1'b0;
        end else begin
            stage_ray <= i_ray;
        end
        stage_hit <= active_in && (i_ray.height < EPSILON);
        stage_prod <= PROD_W'(i_ray.height) * PROD_W'(i_ray.descent);
    end

    assign stage_active = stage_ray.valid && !stage_ray.hit && !stage_ray.max_depth;

    // depth saturates at all ones
    assign depth_sum = {1'b0, stage_ray.depth} + {1'b0, stage_ray.height};
    assign new_depth = depth_sum[FIX_W] ? '1 : depth_sum[FIX_W-1:0];
    assign new_max = (new_depth >= MAX_DIST);

    // height drop for this step, clamped at the plane
    assign step_full = stage_prod[PROD_W-1:ray_pkg::FRAC_BITS];
    assign new_height = (step_full >= STEP_W'(stage_ray.height)) ? '0 :
                        stage_ray.height - ray_pkg::fix_t'(step_full);

    always_ff @(posedge clk) begin
        if (reset) begin
            o_ray.valid <= 1'b0;
        end else begin
            o_ray <= stage_ray;
            if (stage_active) begin
                o_ray.hit <= stage_hit;
                o_ray.max_depth <= new_max;
                // a finished ray keeps the position where it stopped
                if (!stage_hit && !new_max) begin
                    o_ray.height <= new_height;
                    o_ray.depth <= new_depth;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/pixel_scan.sv
`default_nettype none

module pixel_scan #(
    parameter int SCREEN_WIDTH  = 32,
    parameter int SCREEN_HEIGHT = 24
) (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 i_start,
    input  wire ray_pkg::fix_t  i_eye_height,
    input  wire [7:0]           i_tilt_step,
    input  wire ray_pkg::ray_t  i_ray_back,
    output ray_pkg::ray_t       o_ray_head,
    output logic                o_done
);

    localparam ray_pkg::coord_t LAST_X = ray_pkg::coord_t'(SCREEN_WIDTH - 1);
    localparam ray_pkg::coord_t LAST_Y = ray_pkg::coord_t'(SCREEN_HEIGHT - 1);
    localparam ray_pkg::coord_t CENTER_Y = ray_pkg::coord_t'(SCREEN_HEIGHT / 2);
    localparam int CNT_W = $clog2(SCREEN_WIDTH * SCREEN_HEIGHT + 1);

    ray_pkg::coord_t scan_x;
    ray_pkg::coord_t scan_y;
    logic busy;
    logic scan_done;
    logic [CNT_W-1:0] in_flight;
    logic [CNT_W-1:0] in_flight_next;

    logic recirculate;
    logic retire;
    logic launch;
    ray_pkg::coord_t row_off;
    logic [ray_pkg::COORD_W+7:0] descent_full;

    // a ray still marching keeps its slot
    assign recirculate = i_ray_back.valid && !i_ray_back.hit && !i_ray_back.max_depth;
    assign retire = i_ray_back.valid && (i_ray_back.hit || i_ray_back.max_depth);
    assign launch = busy && !scan_done && !recirculate;

    // only rows below the screen center look down at the plane
    assign row_off = (scan_y > CENTER_Y) ? scan_y - CENTER_Y : '0;
    assign descent_full = row_off * i_tilt_step;

    always_comb begin
        case ({launch, retire})
            2'b10:   in_flight_next = in_flight + CNT_W'(1);
            2'b01:   in_flight_next = in_flight - CNT_W'(1);
            default: in_flight_next = in_flight;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            scan_done <= 1'b0;
            scan_x <= '0;
            scan_y <= '0;
            in_flight <= '0;
            o_done <= 1'b0;
        end else begin
            in_flight <= in_flight_next;
            // frame ends once every launched ray has been written
            o_done <= busy && scan_done && (in_flight_next == '0);
            if (!busy) begin
                if (i_start) begin
                    busy <= 1'b1;
                    scan_done <= 1'b0;
                    scan_x <= '0;
                    scan_y <= '0;
                end
            end else if (scan_done && in_flight_next == '0) begin
                busy <= 1'b0;
            end
            if (launch) begin
                if (scan_x == LAST_X) begin
                    scan_x <= '0;
                    if (scan_y == LAST_Y) begin
                        scan_done <= 1'b1;
                    end else begin
                        scan_y <= scan_y + 1'b1;
                    end
                end else begin
                    scan_x <= scan_x + 1'b1;
                end
            end
        end
    end

    // head slot of the loop
    always_ff @(posedge clk) begin
        if (reset) begin
            o_ray_head.valid <= 1'b0;
        end else if (recirculate) begin
            o_ray_head <= i_ray_back;
        end else if (launch) begin
            o_ray_head.valid <= 1'b1;
            o_ray_head.pixel_x <= scan_x;
            o_ray_head.pixel_y <= scan_y;
            o_ray_head.height <= i_eye_height;
            o_ray_head.descent <= ray_pkg::fix_t'(descent_full);
            o_ray_head.depth <= '0;
            o_ray_head.hit <= 1'b0;
            o_ray_head.max_depth <= 1'b0;
        end else begin
            o_ray_head.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hw/ray_pkg.sv
`default_nettype none

package ray_pkg;

    // unsigned Q8.8 fixed point
    localparam int FRAC_BITS = 8;
    localparam int COORD_W = 10;

    typedef logic [15:0] fix_t;
    typedef logic [COORD_W-1:0] coord_t;

    // frame buffer pixel, 3-4-3 bit split
    typedef struct packed {
        logic [2:0] red;
        logic [3:0] green;
        logic [2:0] blue;
    } color_t;

    // one slot of the march loop
    typedef struct packed {
        logic   valid;
        coord_t pixel_x;
        coord_t pixel_y;
        // height above the ground plane, also the scene distance
        fix_t   height;
        // height lost per unit of travelled distance
        fix_t   descent;
        fix_t   depth;
        logic   hit;
        logic   max_depth;
    } ray_t;

    typedef struct packed {
        logic [3:0] red_shift;
        logic [3:0] green_shift;
        logic [3:0] blue_shift;
        logic [3:0] fog_shift;
        logic       red_enable;
        logic       green_enable;
        logic       blue_enable;
        logic       fog_enable;
    } shade_cfg_t;

endpackage

`default_nettype wire
